/* include/config.svh */
// Assertions need a simulator with SVA support and the scan default only suits simulation
`ifndef CONFIG_SVH
`define CONFIG_SVH

// Concurrent assertions in the RTL modules, 1 enables them
`define ARB_ASSERT_EN 1

// Clock cycles per display digit, far too fast for a real board
`define ARB_SCAN_DIV 4

`endif

/* verilog/arb_pkg.sv */
// Segment patterns put segment a in bit 7 and the dot h in bit 0, lit when set
`default_nettype none

package arb_pkg;

    localparam int w_count = 3;

    typedef logic [w_count:0] item_t;   // Source tag on top of the count
    typedef logic [7:0]       seg_t;    // Order a b c d e f g h

    localparam seg_t sign_ready_a   = 8'b1000_0000;  // Segment a
    localparam seg_t sign_ready_b   = 8'b0000_0010;  // Segment g
    localparam seg_t sign_ready_out = 8'b0001_0000;  // Segment d
    localparam seg_t sign_nothing   = 8'b0000_0000;

    // Hex glyphs
    function automatic seg_t hex_to_seg(input logic [3:0] value);
        seg_t seg;
        case (value)
            4'h0: seg = 8'b1111_1100;
            4'h1: seg = 8'b0110_0000;
            4'h2: seg = 8'b1101_1010;
            4'h3: seg = 8'b1111_0010;
            4'h4: seg = 8'b0110_0110;
            4'h5: seg = 8'b1011_0110;
            4'h6: seg = 8'b1011_1110;
            4'h7: seg = 8'b1110_0000;
            4'h8: seg = 8'b1111_1110;
            4'h9: seg = 8'b1111_0110;
            4'ha: seg = 8'b1110_1110;
            4'hb: seg = 8'b0011_1110;
            4'hc: seg = 8'b1001_1100;
            4'hd: seg = 8'b0111_1010;
            4'he: seg = 8'b1001_1110;
            default: seg = 8'b1000_1110;  // f
        endcase
        return seg;
    endfunction

endpackage

`default_nettype wire

/* verilog/flow_fifo.sv */
// Depth must be a power of two of at least 2 and a write is refused while the FIFO is full
`timescale 1ns/1ps
`default_nettype none

`include "config.svh"

module flow_fifo
#(
    parameter int  depth     = 4,
    parameter type payload_t = logic [7:0]
)
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int w_ptr = $clog2(depth);

    payload_t       mem [depth];
    logic [w_ptr:0] wr_ptr;       // Extra top bit marks the wrap
    logic [w_ptr:0] rd_ptr;
    logic           full;
    logic           empty;
    logic           push;
    logic           pop;

    //------------------------------------------------------------------------

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[w_ptr] != rd_ptr[w_ptr])
                && (wr_ptr[w_ptr - 1:0] == rd_ptr[w_ptr - 1:0]);

    assign in_ready  = ~full;
    assign out_valid = ~empty;
    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;

    assign out_data = mem[rd_ptr[w_ptr - 1:0]];  // Head straight from storage

    always_ff @(posedge clk)
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
        end

    always_ff @(posedge clk)
        if (push)
            mem[wr_ptr[w_ptr - 1:0]] <= in_data;

    //------------------------------------------------------------------------

    generate
        if (`ARB_ASSERT_EN)
        begin : g_assert
            localparam logic [w_ptr:0] level_max = (w_ptr + 1)'(depth);

            logic [w_ptr:0] level;

            assign level = wr_ptr - rd_ptr;

            // A lone write grows the fill by one and never past depth
            a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
                push && !pop |=> (level == $past(level) + 1'b1) && (level <= level_max));
        end
    endgenerate

endmodule

`default_nettype wire

/* verilog/counter_source.sv */
// Fire must already include the downstream ready, the count wraps silently from 7 to 0
`timescale 1ns/1ps
`default_nettype none

module counter_source
#(
    parameter logic tag = 1'b0
)
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           fire,
    output arb_pkg::item_t data
);

    logic [arb_pkg::w_count - 1:0] count;

    always_ff @(posedge clk)
        if (!rst_n)
            count <= '0;
        else if (fire)
            count <= count + 1'b1;  // Natural wrap

    assign data = {tag, count};

endmodule

`default_nettype wire

/* verilog/priority_arbiter_2.sv */
// Source A always wins so B can starve and a stalled B item may be replaced by a new A item
`timescale 1ns/1ps
`default_nettype none

`include "config.svh"

module priority_arbiter_2
#(
    parameter int depth = 4
)
(
    input  logic           clk,
    input  logic           rst_n,

    input  logic           a_valid,
    output logic           a_ready,
    input  arb_pkg::item_t a_data,

    input  logic           b_valid,
    output logic           b_ready,
    input  arb_pkg::item_t b_data,

    output logic           out_valid,
    input  logic           out_ready,
    output arb_pkg::item_t out_data
);

    logic           fa_valid;
    logic           fb_valid;
    logic           fb_ready;   // B only drains when A is empty
    arb_pkg::item_t fa_data;
    arb_pkg::item_t fb_data;

    //------------------------------------------------------------------------

    flow_fifo #(.depth (depth), .payload_t (arb_pkg::item_t)) fifo_a
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (a_valid),
        .in_ready  (a_ready),
        .in_data   (a_data),
        .out_valid (fa_valid),
        .out_ready (out_ready),
        .out_data  (fa_data)
    );

    flow_fifo #(.depth (depth), .payload_t (arb_pkg::item_t)) fifo_b
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (b_valid),
        .in_ready  (b_ready),
        .in_data   (b_data),
        .out_valid (fb_valid),
        .out_ready (fb_ready),
        .out_data  (fb_data)
    );

    //------------------------------------------------------------------------

    assign fb_ready  = out_ready & ~fa_valid;
    assign out_valid = fa_valid | fb_valid;
    assign out_data  = fa_valid ? fa_data : fb_data;

    generate
        if (`ARB_ASSERT_EN)
        begin : g_assert
            // Each output transfer pops exactly one FIFO
            a_one_pop : assert property (@(posedge clk) disable iff (!rst_n)
                out_valid && out_ready |-> $onehot({fa_valid & out_ready, fb_valid & fb_ready}));

            // A stalled A item stays on the output
            a_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
                fa_valid && !out_ready |=> out_valid && (out_data == $past(out_data)));
        end
    endgenerate

endmodule

`default_nettype wire

/* verilog/seven_seg_scanner.sv */
// Four digits only with digit bit 0 rightmost, the dot segment is never lit
`timescale 1ns/1ps
`default_nettype none

`include "config.svh"

module seven_seg_scanner
#(
    parameter int scan_div = 4
)
(
    input  logic           clk,
    input  logic           rst_n,

    input  arb_pkg::item_t a_data,
    input  arb_pkg::item_t b_data,
    input  arb_pkg::item_t out_data,

    input  logic           out_valid,
    input  logic           a_ready,
    input  logic           b_ready,
    input  logic           out_ready,

    output arb_pkg::seg_t  abcdefgh,
    output logic [3:0]     digit
);

    localparam int               w_div    = (scan_div > 1) ? $clog2(scan_div) : 1;
    localparam logic [w_div-1:0] div_last = w_div'(scan_div - 1);

    logic [w_div - 1:0] div_cnt;
    logic               step;
    arb_pkg::seg_t      status_seg;

    //------------------------------------------------------------------------
    // Digit ring

    assign step = (div_cnt == div_last);

    always_ff @(posedge clk)
        if (!rst_n)
        begin
            div_cnt <= '0;
            digit   <= 4'b0001;
        end
        else if (step)
        begin
            div_cnt <= '0;
            digit   <= {digit[2:0], digit[3]};  // Move one digit left
        end
        else
            div_cnt <= div_cnt + 1'b1;

    //------------------------------------------------------------------------
    // Segment select

    always_comb
    begin
        status_seg = arb_pkg::sign_nothing;
        if (a_ready)   status_seg |= arb_pkg::sign_ready_a;
        if (b_ready)   status_seg |= arb_pkg::sign_ready_b;
        if (out_ready) status_seg |= arb_pkg::sign_ready_out;
    end

    always_comb
        case (digit)
            4'b0001: abcdefgh = out_valid ? arb_pkg::hex_to_seg(out_data)
                                          : arb_pkg::sign_nothing;  // Blank when idle
            4'b0010: abcdefgh = status_seg;
            4'b0100: abcdefgh = arb_pkg::hex_to_seg(b_data);
            4'b1000: abcdefgh = arb_pkg::hex_to_seg(a_data);
            default: abcdefgh = arb_pkg::sign_nothing;
        endcase

    generate
        if (`ARB_ASSERT_EN)
        begin : g_assert
            a_digit_onehot : assert property (@(posedge clk) disable iff (!rst_n)
                $onehot(digit));
        end
    endgenerate

endmodule

`default_nettype wire

/* verilog/arb_demo_top.sv */
// Keys are active high when pressed and key 0 pressed stalls the output stream
`timescale 1ns/1ps
`default_nettype none

`include "config.svh"

module arb_demo_top
#(
    parameter int depth    = 4,
    parameter int scan_div = `ARB_SCAN_DIV
)
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic [2:0]    key,
    output logic [6:0]    led,
    output arb_pkg::seg_t abcdefgh,
    output logic [3:0]    digit
);

    logic           a_valid;
    logic           a_ready;
    arb_pkg::item_t a_data;

    logic           b_valid;
    logic           b_ready;
    arb_pkg::item_t b_data;

    logic           out_valid;
    logic           out_ready;
    arb_pkg::item_t out_data;

    //------------------------------------------------------------------------

    assign a_valid   =  key[2];
    assign b_valid   =  key[1];
    assign out_ready = ~key[0];  // Ready unless the key is held

    counter_source #(.tag (1'b0)) src_a  // 0 to 7
    (
        .clk   (clk),
        .rst_n (rst_n),
        .fire  (a_valid & a_ready),
        .data  (a_data)
    );

    counter_source #(.tag (1'b1)) src_b  // 8 to f
    (
        .clk   (clk),
        .rst_n (rst_n),
        .fire  (b_valid & b_ready),
        .data  (b_data)
    );

    priority_arbiter_2 #(.depth (depth)) arb
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_valid   (a_valid),
        .a_ready   (a_ready),
        .a_data    (a_data),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .b_data    (b_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    //------------------------------------------------------------------------

    seven_seg_scanner #(.scan_div (scan_div)) disp
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_data    (a_data),
        .b_data    (b_data),
        .out_data  (out_data),
        .out_valid (out_valid),
        .a_ready   (a_ready),
        .b_ready   (b_ready),
        .out_ready (out_ready),
        .abcdefgh  (abcdefgh),
        .digit     (digit)
    );

    assign led = {b_ready, a_ready, out_valid, out_data};

endmodule

`default_nettype wire

/* verif/arb_checker.sv */
// Samples on the falling edge and assumes key 0 stalls the output and 3-bit counts under a tag
`timescale 1ns/1ps
`default_nettype none

module arb_checker
#(
    parameter int depth = 4
)
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] key,
    input  logic [6:0] led,
    input  logic [7:0] abcdefgh,
    input  logic [3:0] digit,
    output int         errors
);

    logic [3:0] queue_a [$];   // Items held in FIFO A
    logic [3:0] queue_b [$];
    logic [2:0] count_a;
    logic [2:0] count_b;
    bit         after_reset;
    int         error_count = 0;

    assign errors = error_count;

    //------------------------------------------------------------------------
    // Reference glyphs, segment a in bit 7

    function automatic logic [7:0] glyph(input logic [3:0] value);
        case (value)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110;
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010;
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

    // Segment a for A ready, g for B ready, d for output ready
    function automatic logic [7:0] status_glyph(input bit a_rdy, input bit b_rdy,
                                                input bit o_rdy);
        return {a_rdy, 2'b00, o_rdy, 2'b00, b_rdy, 1'b0};
    endfunction

    task automatic compare_value(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("ERROR at %0d ns: %s expected %h, actual %h",
                     $time, name, expected, actual);
        end
    endtask

    //------------------------------------------------------------------------
    // Model and compare

    always @(negedge clk)
    begin
        bit         ready_a;
        bit         ready_b;
        bit         valid;
        logic [3:0] head;

        if (!rst_n)
        begin
            queue_a.delete();
            queue_b.delete();
            count_a     = 3'd0;
            count_b     = 3'd0;
            after_reset = 1'b1;
        end
        else
        begin
            ready_a = queue_a.size() < depth;
            ready_b = queue_b.size() < depth;
            valid   = (queue_a.size() + queue_b.size()) != 0;
            head    = 4'h0;
            if (queue_a.size() != 0)
                head = queue_a[0];    // A always wins
            else if (valid)
                head = queue_b[0];

            if (after_reset)
                compare_value("digit", 8'h01, {4'h0, digit});
            after_reset = 1'b0;

            compare_value("led[5] a_ready", {7'd0, ready_a}, {7'd0, led[5]});
            compare_value("led[6] b_ready", {7'd0, ready_b}, {7'd0, led[6]});
            compare_value("led[4] out_valid", {7'd0, valid}, {7'd0, led[4]});
            if (valid)
                compare_value("led[3:0] out_data", {4'h0, head}, {4'h0, led[3:0]});
            compare_value("digit one-hot", 8'h01, {7'd0, $onehot(digit)});
            if (digit == 4'b0001)
                compare_value("abcdefgh digit 0", valid ? glyph(head) : 8'h00, abcdefgh);
            if (digit == 4'b0010)
                compare_value("abcdefgh digit 1", status_glyph(ready_a, ready_b, !key[0]),
                              abcdefgh);

            // Digits 2 and 3 show the item each source offers now
            if (digit == 4'b0100)
                compare_value("abcdefgh digit 2", glyph({1'b1, count_b}), abcdefgh);
            if (digit == 4'b1000)
                compare_value("abcdefgh digit 3", glyph({1'b0, count_a}), abcdefgh);

            // Transfers of the coming edge, pop before push
            if (valid && !key[0])
            begin
                if (queue_a.size() != 0)
                    head = queue_a.pop_front();
                else
                    head = queue_b.pop_front();
            end
            if (key[2] && ready_a)
            begin
                queue_a.push_back({1'b0, count_a});
                count_a = count_a + 3'd1;   // 7 wraps to 0
            end
            if (key[1] && ready_b)
            begin
                queue_b.push_back({1'b1, count_b});
                count_b = count_b + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tb_arb_demo.sv */
// Runs the DUT at depth 4 with the default scan divider and gives up on any wait after 200 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_arb_demo;

    localparam int depth = 4;
    localparam int limit = 200;   // Cycles allowed per wait

    logic        clk;
    logic        rst_n;
    logic [2:0]  key;
    logic [6:0]  led;
    logic [7:0]  abcdefgh;
    logic [3:0]  digit;
    int          errors;
    int          errors_before;
    int          passed;
    int          failed;
    bit          wait_failed;
    logic [31:0] lfsr;

    arb_demo_top #(.depth (depth)) uut
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .key      (key),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    arb_checker #(.depth (depth)) chk
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .key      (key),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .errors   (errors)
    );

    always #20 clk = ~clk;

    //------------------------------------------------------------------------
    // Stimulus helpers

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic drive_keys(input logic [2:0] value);
        @(posedge clk);
        key <= value;
    endtask

    task automatic drive_random_keys(input int cycles);
        logic [2:0] value;
        repeat (cycles)
        begin
            for (int i = 0; i < 3; i++)
            begin
                lfsr     = lfsr_next(lfsr);
                value[i] = lfsr[0];   // One step per key bit
            end
            drive_keys(value);
        end
    endtask

    // Waits until the masked {digit, led} equals value
    task automatic wait_for(input logic [10:0] mask, input logic [10:0] value,
                            input string what);
        int n;
        n = 0;
        @(negedge clk);
        while ((({digit, led} & mask) != value) && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (({digit, led} & mask) != value)
        begin
            $display("Timeout after %0d cycles waiting for %s", limit, what);
            wait_failed = 1'b1;
        end
    endtask

    task automatic start_test;
        errors_before = errors;
        wait_failed   = 1'b0;
    endtask

    task automatic finish_test(input int number, input string name);
        @(posedge clk);
        if (errors == errors_before && !wait_failed)
        begin
            passed++;
            $display("Test %0d %s: ok", number, name);
        end
        else
        begin
            failed++;
            $display("Test %0d %s: failed", number, name);
        end
    endtask

    //------------------------------------------------------------------------

    initial
    begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        key    = 3'b000;
        lfsr   = 32'h051f_428f;
        passed = 0;
        failed = 0;

        start_test();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(negedge clk);
        finish_test(1, "reset state");

        start_test();
        drive_keys(3'b101);                          // A offers, output stalled
        wait_for(11'h020, 11'h000, "led[5] to fall");
        repeat (4) @(negedge clk);
        drive_keys(3'b000);
        wait_for(11'h010, 11'h000, "the output to drain");
        finish_test(2, "fill and back-pressure");

        start_test();
        drive_keys(3'b111);
        wait_for(11'h060, 11'h000, "led[5] and led[6] to fall");
        drive_keys(3'b000);
        wait_for(11'h010, 11'h000, "the output to drain");
        finish_test(3, "priority");

        start_test();
        drive_random_keys(2000);
        drive_keys(3'b000);
        wait_for(11'h010, 11'h000, "the output to drain");
        finish_test(4, "random stress");

        start_test();
        drive_random_keys(40);
        wait_for(11'h780, 11'h080, "digit 0001");
        wait_for(11'h780, 11'h100, "digit 0010");
        drive_keys(3'b000);
        wait_for(11'h010, 11'h000, "the output to drain");
        finish_test(5, "display");

        $display("Tests passed: %0d, failed: %0d, check errors: %0d", passed, failed, errors);
        if (failed == 0 && errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
verilog/arb_pkg.sv
verilog/flow_fifo.sv
verilog/counter_source.sv
verilog/priority_arbiter_2.sv
verilog/seven_seg_scanner.sv
verilog/arb_demo_top.sv
verif/arb_checker.sv
verif/tb_arb_demo.sv

/* Makefile */
# Verilator build and run of the arbiter demo testbench
# Any variable can be set on the command line, for example make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_arb_demo
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and fail if the log holds the fail message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "TEST FAIL" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
